//--- verilog.f
+incdir+tests
hdl/ahb_sram_pkg.sv
hdl/ram_req_if.sv
hdl/ahb_addr_ctrl.sv
hdl/lane_strobe_decode.sv
hdl/byte_lane_bank.sv
hdl/ahb_sram_top.sv
tests/tb_ahb_sram.sv

//--- run_sim.sh
#!/bin/sh
# build the AHB SRAM testbench with Verilator, run it and check the log for the pass line

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module tb_ahb_sram -f verilog.f -o tb_ahb_sram \
    && ./obj_dir/tb_ahb_sram > sim.log 2>&1 \
    || { echo "build or run failed"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -qx '>>> PASS' sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- tests/tb_vectors.svh
// AHB SRAM stimulus table with one address phase per row, applied in order by the testbench
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// the columns are kind, hsel, hsize and haddr
// idle rows drive htrans IDLE with hwrite high
// unselected rows drive NONSEQ or SEQ with hsel low

localparam logic [1:0] KIND_IDLE  = 2'd0;
localparam logic [1:0] KIND_WRITE = 2'd1;
localparam logic [1:0] KIND_READ  = 2'd2;

typedef struct packed {
    logic [1:0]  kind;
    logic        sel;
    logic [2:0]  size;
    logic [31:0] addr;
} vec_t;

localparam int NUM_VECTORS = 40;

localparam vec_t VECTORS [NUM_VECTORS] = '{
    {KIND_WRITE, 1'b1, SIZE_QWORD, 32'h0000_0010},    // fill every row that is read later
    {KIND_WRITE, 1'b1, SIZE_QWORD, 32'h0000_0020},
    {KIND_WRITE, 1'b1, SIZE_QWORD, 32'h0000_0030},
    {KIND_WRITE, 1'b1, SIZE_QWORD, 32'h0000_0100},
    {KIND_WRITE, 1'b1, SIZE_QWORD, 32'h0000_0200},
    {KIND_WRITE, 1'b1, SIZE_QWORD, 32'h0000_0ff0},
    {KIND_IDLE,  1'b1, SIZE_QWORD, 32'h0000_0ff0},
    {KIND_READ,  1'b1, SIZE_QWORD, 32'h0000_0ff0},    // full row back after an idle cycle
    {KIND_READ,  1'b1, SIZE_QWORD, 32'h0000_0010},
    {KIND_READ,  1'b1, SIZE_QWORD, 32'h0000_0020},
    // narrow writes merge into row 2
    {KIND_WRITE, 1'b1, SIZE_BYTE,  32'h0000_0025},
    {KIND_WRITE, 1'b1, SIZE_HWORD, 32'h0000_002b},
    {KIND_WRITE, 1'b1, SIZE_WORD,  32'h0000_0026},
    {KIND_WRITE, 1'b1, SIZE_DWORD, 32'h0000_002f},
    {KIND_WRITE, 1'b1, SIZE_BYTE,  32'h0000_0020},
    {KIND_IDLE,  1'b1, SIZE_BYTE,  32'h0000_0020},
    {KIND_READ,  1'b1, SIZE_WORD,  32'h0000_0020},
    {KIND_WRITE, 1'b1, SIZE_HWORD, 32'h0000_0031},
    {KIND_WRITE, 1'b1, SIZE_WORD,  32'h0000_003e},
    {KIND_IDLE,  1'b0, SIZE_WORD,  32'h0000_003e},
    {KIND_READ,  1'b1, SIZE_BYTE,  32'h0000_0033},
    // reads straight after writes stall for one cycle
    {KIND_WRITE, 1'b1, SIZE_WORD,  32'h0000_0104},
    {KIND_READ,  1'b1, SIZE_WORD,  32'h0000_0104},
    {KIND_WRITE, 1'b1, SIZE_BYTE,  32'h0000_0209},
    {KIND_READ,  1'b1, SIZE_QWORD, 32'h0000_0030},    // other row keeps its old data
    {KIND_WRITE, 1'b1, SIZE_DWORD, 32'h0000_0018},
    {KIND_READ,  1'b1, SIZE_DWORD, 32'h0000_0010},
    {KIND_READ,  1'b1, SIZE_QWORD, 32'h0000_0200},
    // unselected and idle transfers must not write
    {KIND_WRITE, 1'b0, SIZE_QWORD, 32'h0000_0010},
    {KIND_IDLE,  1'b1, SIZE_QWORD, 32'h0000_0020},
    {KIND_WRITE, 1'b0, SIZE_BYTE,  32'h0000_0ff3},
    {KIND_READ,  1'b1, SIZE_QWORD, 32'h0000_0010},
    {KIND_READ,  1'b1, SIZE_QWORD, 32'h0000_0020},
    {KIND_READ,  1'b1, SIZE_QWORD, 32'habcd_1ff0},    // aliases row 0xff
    {KIND_WRITE, 1'b1, SIZE_BYTE,  32'h8000_0101},
    {KIND_IDLE,  1'b1, SIZE_BYTE,  32'h8000_0101},
    {KIND_READ,  1'b1, SIZE_QWORD, 32'h0000_0100},
    {KIND_READ,  1'b1, SIZE_QWORD, 32'h7fff_f100},
    {KIND_WRITE, 1'b1, SIZE_QWORD, 32'h0000_0030},
    {KIND_READ,  1'b1, SIZE_QWORD, 32'h0000_0030}
};

`endif

//--- tests/tb_ahb_sram.sv
// AHB SRAM testbench with table-driven transfers checked against a shadow byte memory
`timescale 1ns/1ps

module tb_ahb_sram import ahb_sram_pkg::*; ();

    localparam logic [1:0] HTRANS_IDLE = 2'b00;
    localparam logic [1:0] RESP_OKAY   = 2'b00;

    logic        hclk;
    logic        hrst_b;
    logic        hsel;
    logic [1:0]  htrans;
    logic [2:0]  hsize;
    logic [31:0] haddr;
    logic        hwrite;
    bus_data_t   hwdata;
    bus_data_t   hrdata;
    logic        hready;
    logic [1:0]  hresp;

    logic [7:0]  shadow_mem [2**ROW_WIDTH][DATA_BYTES];
    integer      seed = 32'hed663b78;
    int          error_count;
    int          check_count;
    int          cycle_count;

    `include "tb_vectors.svh"

    localparam int TIMEOUT_CYCLES = 3 * NUM_VECTORS + 100;

    ahb_sram_top i_dut (
        .hclk   (hclk),
        .hrst_b (hrst_b),
        .hsel   (hsel),
        .htrans (htrans),
        .hsize  (hsize),
        .haddr  (haddr),
        .hwrite (hwrite),
        .hwdata (hwdata),
        .hrdata (hrdata),
        .hready (hready),
        .hresp  (hresp)
    );

    always #10 hclk = ~hclk;

    always @(posedge hclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("error: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic check_value(input string name, input bus_data_t actual,
                               input bus_data_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("mismatch %s: got %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    // a lane is hit when it falls in the same naturally aligned block of 2**size lanes
    function automatic bit lane_in_transfer(input logic [2:0] size, input logic [31:0] addr,
                                            input int lane);
        int lane_addr;
        if (size > SIZE_QWORD) begin
            return 1'b0;
        end
        lane_addr = int'(addr[LANE_SEL_WIDTH-1:0]);
        return (lane >> size) == (lane_addr >> size);
    endfunction

    function automatic int row_of(input logic [31:0] addr);
        return int'(addr[MEM_ADDR_WIDTH-1:LANE_SEL_WIDTH]);
    endfunction

    function automatic bus_data_t expected_row(input int row);
        bus_data_t data;
        for (int lane = 0; lane < DATA_BYTES; lane++) begin
            data[8*lane +: 8] = shadow_mem[row][lane];
        end
        return data;
    endfunction

    task automatic shadow_write(input logic [2:0] size, input logic [31:0] addr,
                                input bus_data_t data);
        int row;
        row = row_of(addr);
        for (int lane = 0; lane < DATA_BYTES; lane++) begin
            if (lane_in_transfer(size, addr, lane)) begin
                shadow_mem[row][lane] = data[8*lane +: 8];
            end
        end
    endtask

    task automatic next_random_data(output bus_data_t data);
        for (int w = 0; w < DATA_WIDTH / 32; w++) begin
            data[32*w +: 32] = $random(seed);
        end
    endtask

    task automatic drive_idle();
        hsel   = 1'b0;
        htrans = HTRANS_IDLE;
        hwrite = 1'b0;
        hsize  = SIZE_BYTE;
        haddr  = '0;
    endtask

    task automatic drive_address_phase(input vec_t xfer, input logic prev_active);
        hsel   = xfer.sel;
        hsize  = xfer.size;
        haddr  = xfer.addr;
        hwrite = (xfer.kind != KIND_READ);      // idle rows look like writes
        if (xfer.kind == KIND_IDLE) begin
            htrans = HTRANS_IDLE;
        end else begin
            htrans = prev_active ? HTRANS_SEQ : HTRANS_NONSEQ;
        end
    endtask

    initial begin
        int          vec_idx;
        logic        prev_active;
        logic        prev_write;
        logic        dp_valid;
        logic        dp_write;
        logic [2:0]  dp_size;
        logic [31:0] dp_addr;
        bus_data_t   dp_wdata;
        int          dp_waits;
        int          dp_expect_waits;
        vec_t        xfer;

        hclk   = 1'b0;
        hrst_b = 1'b0;
        hwdata = '0;
        drive_idle();

        repeat (16) begin
            @(negedge hclk);
            check_value("hready", bus_data_t'(hready), '0);
        end
        @(posedge hclk);
        #2;
        hrst_b = 1'b1;
        @(negedge hclk);
        check_value("hready", bus_data_t'(hready), '0);    // first cycle out of reset
        @(posedge hclk);
        #2;
        @(negedge hclk);
        check_value("hready", bus_data_t'(hready), bus_data_t'(1));
        @(posedge hclk);
        #2;

        vec_idx  = 0;
        dp_valid = 1'b0;
        dp_write = 1'b0;
        dp_waits = 0;
        while (vec_idx < NUM_VECTORS || dp_valid) begin
            if (vec_idx < NUM_VECTORS) begin
                prev_active = 1'b0;
                if (vec_idx > 0) begin
                    prev_active = (VECTORS[vec_idx-1].kind != KIND_IDLE);
                end
                drive_address_phase(VECTORS[vec_idx], prev_active);
            end else begin
                drive_idle();
            end
            if (dp_valid && dp_write) begin
                hwdata = dp_wdata;
            end else begin
                next_random_data(hwdata);   // junk on the bus when nothing is written
            end

            @(negedge hclk);
            check_value("hresp", bus_data_t'(hresp), bus_data_t'(RESP_OKAY));
            if (hready) begin
                // the data phase in flight completes at the coming edge
                if (dp_valid) begin
                    check_value("hready wait states", bus_data_t'(dp_waits),
                                bus_data_t'(dp_expect_waits));
                    if (dp_write) begin
                        shadow_write(dp_size, dp_addr, dp_wdata);
                    end else begin
                        check_value("hrdata", hrdata, expected_row(row_of(dp_addr)));
                    end
                end
                prev_write = dp_valid && dp_write;
                if (vec_idx < NUM_VECTORS) begin
                    xfer     = VECTORS[vec_idx];
                    dp_valid = (xfer.kind != KIND_IDLE) && xfer.sel;
                    dp_write = (xfer.kind == KIND_WRITE);
                    dp_size  = xfer.size;
                    dp_addr  = xfer.addr;
                    dp_waits = 0;
                    dp_expect_waits = (prev_write && dp_valid && !dp_write) ? 1 : 0;
                    if (dp_valid && dp_write) begin
                        next_random_data(dp_wdata);
                    end
                    vec_idx++;
                end else begin
                    dp_valid = 1'b0;
                end
            end else begin
                dp_waits++;
                if (!dp_valid) begin
                    // without a transfer in its data phase the bus stays ready
                    check_value("hready", bus_data_t'(hready), bus_data_t'(1));
                end
            end
            @(posedge hclk);
            #2;
        end

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- hdl/ahb_sram_top.sv
// AHB-Lite SRAM slave with a 128-bit bus over sixteen byte lanes and a one-cycle hazard stall
`timescale 1ns/1ps

module ahb_sram_top import ahb_sram_pkg::*; (
    input  logic        hclk,
    input  logic        hrst_b,
    input  logic        hsel,
    input  logic [1:0]  htrans,
    input  logic [2:0]  hsize,
    input  logic [31:0] haddr,
    input  logic        hwrite,
    input  bus_data_t   hwdata,
    output bus_data_t   hrdata,
    output logic        hready,
    output logic [1:0]  hresp
);

    logic wr_accept;

    ram_req_if ram_if ();

    ahb_addr_ctrl i_addr_ctrl (
        .hclk      (hclk),
        .hrst_b    (hrst_b),
        .hsel      (hsel),
        .htrans    (htrans),
        .hwrite    (hwrite),
        .haddr     (haddr),
        .hready    (hready),
        .wr_accept (wr_accept),
        .ram       (ram_if.ctrl)
    );

    lane_strobe_decode i_lane_dec (
        .hclk      (hclk),
        .hrst_b    (hrst_b),
        .wr_accept (wr_accept),
        .hsize     (hsize),
        .lane_addr (haddr[LANE_SEL_WIDTH-1:0]),
        .ram       (ram_if.lanes)
    );

    byte_lane_bank i_bank (
        .hclk (hclk),
        .ram  (ram_if.bank)
    );

    // hwdata is already in its data phase when the lane enables fire
    assign ram_if.wdata = hwdata;
    assign hrdata       = ram_if.rdata;

    assign hresp = HRESP_OKAY;  // the slave never signals an error

endmodule

//--- hdl/byte_lane_bank.sv
// byte lane bank of sixteen byte-wide synchronous RAM lanes sharing one row address
`timescale 1ns/1ps

module byte_lane_bank import ahb_sram_pkg::*; (
    input  logic    hclk,
    ram_req_if.bank ram
);

    genvar lane;

    generate
        for (lane = 0; lane < DATA_BYTES; lane++) begin : g_lane
            logic [7:0] lane_mem [2**ROW_WIDTH];
            logic [7:0] rd_byte;

            always_ff @(posedge hclk) begin
                if (ram.wen[lane]) begin
                    lane_mem[ram.row_addr] <= ram.wdata[8*lane +: 8];
                end
            end

            // a same-cycle write returns old contents and the hazard stall keeps reads off it
            always_ff @(posedge hclk) begin
                rd_byte <= lane_mem[ram.row_addr];
            end

            assign ram.rdata[8*lane +: 8] = rd_byte;   // lane 0 in the low byte
        end
    endgenerate

endmodule

//--- hdl/lane_strobe_decode.sv
// lane strobe decoder that turns size and low address of an accepted write into lane enables
`timescale 1ns/1ps

module lane_strobe_decode import ahb_sram_pkg::*; (
    input  logic                      hclk,
    input  logic                      hrst_b,
    input  logic                      wr_accept,
    input  logic [2:0]                hsize,
    input  logic [LANE_SEL_WIDTH-1:0] lane_addr,
    ram_req_if.lanes                  ram
);

    lane_mask_t                size_mask;
    logic [LANE_SEL_WIDTH-1:0] align;
    lane_mask_t                lane_mask;

    // the address bits below the transfer size are dropped so the lanes stay aligned
    always_comb begin
        case (hsize)
            SIZE_BYTE: begin
                size_mask = lane_mask_t'(16'h0001);
                align     = lane_addr;
            end
            SIZE_HWORD: begin
                size_mask = lane_mask_t'(16'h0003);
                align     = {lane_addr[LANE_SEL_WIDTH-1:1], 1'b0};
            end
            SIZE_WORD: begin
                size_mask = lane_mask_t'(16'h000f);
                align     = {lane_addr[LANE_SEL_WIDTH-1:2], 2'b00};
            end
            SIZE_DWORD: begin
                size_mask = lane_mask_t'(16'h00ff);
                align     = {lane_addr[LANE_SEL_WIDTH-1:3], 3'b000};
            end
            SIZE_QWORD: begin
                size_mask = lane_mask_t'(16'hffff);
                align     = '0;
            end
            default: begin
                size_mask = '0;                 // sizes wider than the bus write nothing
                align     = '0;
            end
        endcase
    end

    assign lane_mask = size_mask << align;

    // enables move to the data phase, when hwdata is on the bus
    always_ff @(posedge hclk or negedge hrst_b) begin
        if (!hrst_b) begin
            ram.wen <= '0;
        end else begin
            ram.wen <= wr_accept ? lane_mask : '0;
        end
    end

endmodule

//--- hdl/ahb_addr_ctrl.sv
// AHB address controller that accepts transfers, stalls hazard reads and picks the row address
`timescale 1ns/1ps

module ahb_addr_ctrl import ahb_sram_pkg::*; (
    input  logic        hclk,
    input  logic        hrst_b,
    input  logic        hsel,
    input  logic [1:0]  htrans,
    input  logic        hwrite,
    input  logic [31:0] haddr,
    output logic        hready,
    output logic        wr_accept,
    ram_req_if.ctrl     ram
);

    logic      trans_valid;
    logic      rd_accept;
    logic      write_dphase;
    logic      rd_hazard;
    logic      use_row_ff;
    row_addr_t row_ff;
    row_addr_t live_row;

    assign trans_valid = hsel && hready && ((htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ));
    assign wr_accept   = trans_valid && hwrite;
    assign rd_accept   = trans_valid && !hwrite;

    // the RAM port belongs to the pending write during its data phase
    assign rd_hazard = write_dphase && rd_accept;

    always_ff @(posedge hclk or negedge hrst_b) begin
        if (!hrst_b) begin
            write_dphase <= 1'b0;
        end else begin
            write_dphase <= wr_accept;  // no write can be accepted while stalled
        end
    end

    // low out of reset, then low for one cycle after each hazard read
    always_ff @(posedge hclk or negedge hrst_b) begin
        if (!hrst_b) begin
            hready <= 1'b0;
        end else begin
            hready <= !rd_hazard;
        end
    end

    always_ff @(posedge hclk) begin
        if (trans_valid) begin
            row_ff <= haddr[MEM_ADDR_WIDTH-1:LANE_SEL_WIDTH];
        end
    end

    // bits above MEM_ADDR_WIDTH alias onto the same rows
    assign live_row = haddr[MEM_ADDR_WIDTH-1:LANE_SEL_WIDTH];

    // a stalled read replays its registered row so the data arrives one cycle late
    assign use_row_ff   = write_dphase || !hready;
    assign ram.row_addr = use_row_ff ? row_ff : live_row;

endmodule

//--- hdl/ram_req_if.sv
// RAM request interface carrying row address, lane enables and data to the byte lane bank
`timescale 1ns/1ps

interface ram_req_if import ahb_sram_pkg::*; ();

    row_addr_t  row_addr;   // shared by all sixteen lanes
    lane_mask_t wen;        // lines up with the write data phase
    bus_data_t  wdata;
    bus_data_t  rdata;      // registered, one cycle after row_addr

    modport ctrl (
        output row_addr
    );

    modport lanes (
        output wen
    );

    modport bank (
        input  row_addr,
        input  wen,
        input  wdata,
        output rdata
    );

endinterface

//--- hdl/ahb_sram_pkg.sv
// AHB SRAM package with the memory geometry, AHB transfer codes and lane types
package ahb_sram_pkg;

    // sixteen byte lanes make up one 128-bit row
    localparam int DATA_BYTES     = 16;
    localparam int DATA_WIDTH     = DATA_BYTES * 8;

    localparam int MEM_ADDR_WIDTH = 12;                 // 4 KiB of decoded byte address
    localparam int LANE_SEL_WIDTH = 4;                  // low address bits that pick a lane
    localparam int ROW_WIDTH      = MEM_ADDR_WIDTH - LANE_SEL_WIDTH;

    // hsize encodings up to the full bus width
    localparam logic [2:0] SIZE_BYTE  = 3'd0;
    localparam logic [2:0] SIZE_HWORD = 3'd1;
    localparam logic [2:0] SIZE_WORD  = 3'd2;
    localparam logic [2:0] SIZE_DWORD = 3'd3;
    localparam logic [2:0] SIZE_QWORD = 3'd4;

    // the slave acts only on the two active htrans codes and ignores IDLE and BUSY
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
    localparam logic [1:0] HTRANS_SEQ    = 2'b11;

    localparam logic [1:0] HRESP_OKAY    = 2'b00;

    typedef logic [ROW_WIDTH-1:0]  row_addr_t;
    typedef logic [DATA_BYTES-1:0] lane_mask_t;         // bit n enables byte lane n
    typedef logic [DATA_WIDTH-1:0] bus_data_t;

endpackage
